// ==== riscv_pkg.sv ====
// RV32I core shared definitions
package riscv_pkg;

    // data and address width
    localparam int XLEN = 32;
    // pc after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 encodings for alu ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // branch conditions
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    // word-only memory access, plain jalr
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_JALR    = 3'b000;

    // instruction format, one value per encoding class
    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE
    } instr_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    // next pc source
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JALR} pc_sel_e;
    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;
    // writeback source
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef struct packed {
        pc_sel_e  pc_sel;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        wb_sel_e  wb_sel;
        alu_op_e  alu_op;
        logic     mem_wr;
        logic     rf_en;
    } ctrl_t;

    // no write, no jump: what an illegal encoding turns into
    localparam ctrl_t CTRL_NOP = '{
        pc_sel: PC_PLUS4, op1_sel: OP1_RS1, op2_sel: OP2_IMM, wb_sel: WB_ALU,
        alu_op: ALU_ADD, mem_wr: 1'b0, rf_en: 1'b0
    };

    typedef struct packed {
        instr_fmt_e      fmt;
        opcode_e         opcode;
        logic [2:0]      funct3;
        logic            funct7_b5;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
    } dec_t;

endpackage

// ==== riscv_decode.sv ====
// Instruction field decoder
`timescale 1ns/100ps

module riscv_decode
    (
        input  logic [31:0]      instr_i,
        output riscv_pkg::dec_t  dec_o
    );

    riscv_pkg::opcode_e    opcode;
    riscv_pkg::instr_fmt_e fmt;
    logic [31:0]           imm_i_type;
    logic [31:0]           imm_s_type;
    logic [31:0]           imm_b_type;
    logic [31:0]           imm_u_type;
    logic [31:0]           imm_j_type;

    // unknown opcodes fall to FMT_NONE below
    assign opcode = riscv_pkg::opcode_e'(instr_i[6:0]);

    // format from major opcode
    always_comb
    begin
        case (opcode)
            riscv_pkg::OP     : fmt = riscv_pkg::FMT_R;
            riscv_pkg::OP_IMM : fmt = riscv_pkg::FMT_I;
            riscv_pkg::LOAD   : fmt = riscv_pkg::FMT_I;
            riscv_pkg::JALR   : fmt = riscv_pkg::FMT_I;
            riscv_pkg::STORE  : fmt = riscv_pkg::FMT_S;
            riscv_pkg::BRANCH : fmt = riscv_pkg::FMT_B;
            riscv_pkg::LUI    : fmt = riscv_pkg::FMT_U;
            riscv_pkg::AUIPC  : fmt = riscv_pkg::FMT_U;
            riscv_pkg::JAL    : fmt = riscv_pkg::FMT_J;
            default           : fmt = riscv_pkg::FMT_NONE;
        endcase
    end

    // immediates, all sign-extended from bit 31 except U
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    // branch offset, bit 0 always zero
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    // jal offset, scrambled like the branch one
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    always_comb
    begin
        dec_o.fmt       = fmt;
        dec_o.opcode    = opcode;
        dec_o.funct3    = instr_i[14:12];
        dec_o.funct7_b5 = instr_i[30];
        dec_o.rs1       = instr_i[19:15];
        dec_o.rs2       = instr_i[24:20];
        dec_o.rd        = instr_i[11:7];
        // pick immediate by format
        case (fmt)
            riscv_pkg::FMT_I : dec_o.imm = imm_i_type;
            riscv_pkg::FMT_S : dec_o.imm = imm_s_type;
            riscv_pkg::FMT_B : dec_o.imm = imm_b_type;
            riscv_pkg::FMT_U : dec_o.imm = imm_u_type;
            riscv_pkg::FMT_J : dec_o.imm = imm_j_type;
            default          : dec_o.imm = '0;
        endcase
    end

endmodule

// ==== riscv_control.sv ====
// Instruction control decoder
`timescale 1ns/100ps

module riscv_control
    (
        input  riscv_pkg::dec_t   dec_i,
        output riscv_pkg::ctrl_t  ctrl_o
    );

    // funct7 bit 5 in front of funct3, as for R-type
    logic [3:0] funct_r;

    assign funct_r = {dec_i.funct7_b5, dec_i.funct3};

    always_comb
    begin
        // start from nop, each format overrides what it needs
        ctrl_o = riscv_pkg::CTRL_NOP;
        case (dec_i.fmt)
            riscv_pkg::FMT_R :
            begin
                ctrl_o.op2_sel = riscv_pkg::OP2_RS2;
                ctrl_o.rf_en   = 1'b1;
                case (funct_r)
                    {1'b0, riscv_pkg::F3_ADD_SUB} : ctrl_o.alu_op = riscv_pkg::ALU_ADD;
                    {1'b1, riscv_pkg::F3_ADD_SUB} : ctrl_o.alu_op = riscv_pkg::ALU_SUB;
                    {1'b0, riscv_pkg::F3_SLL}     : ctrl_o.alu_op = riscv_pkg::ALU_SLL;
                    {1'b0, riscv_pkg::F3_SLT}     : ctrl_o.alu_op = riscv_pkg::ALU_SLT;
                    {1'b0, riscv_pkg::F3_SLTU}    : ctrl_o.alu_op = riscv_pkg::ALU_SLTU;
                    {1'b0, riscv_pkg::F3_XOR}     : ctrl_o.alu_op = riscv_pkg::ALU_XOR;
                    {1'b0, riscv_pkg::F3_SR}      : ctrl_o.alu_op = riscv_pkg::ALU_SRL;
                    {1'b1, riscv_pkg::F3_SR}      : ctrl_o.alu_op = riscv_pkg::ALU_SRA;
                    {1'b0, riscv_pkg::F3_OR}      : ctrl_o.alu_op = riscv_pkg::ALU_OR;
                    {1'b0, riscv_pkg::F3_AND}     : ctrl_o.alu_op = riscv_pkg::ALU_AND;
                    // unknown funct, no writeback
                    default                       : ctrl_o.rf_en  = 1'b0;
                endcase
            end

            riscv_pkg::FMT_I :
            begin
                ctrl_o.rf_en = 1'b1;
                if (dec_i.opcode == riscv_pkg::OP_IMM)
                begin
                    case (dec_i.funct3)
                        riscv_pkg::F3_ADD_SUB : ctrl_o.alu_op = riscv_pkg::ALU_ADD;
                        riscv_pkg::F3_SLT     : ctrl_o.alu_op = riscv_pkg::ALU_SLT;
                        riscv_pkg::F3_SLTU    : ctrl_o.alu_op = riscv_pkg::ALU_SLTU;
                        riscv_pkg::F3_XOR     : ctrl_o.alu_op = riscv_pkg::ALU_XOR;
                        riscv_pkg::F3_OR      : ctrl_o.alu_op = riscv_pkg::ALU_OR;
                        riscv_pkg::F3_AND     : ctrl_o.alu_op = riscv_pkg::ALU_AND;
                        // slli only with funct7 bit 5 clear
                        riscv_pkg::F3_SLL     :
                            if (dec_i.funct7_b5)
                                ctrl_o.rf_en  = 1'b0;
                            else
                                ctrl_o.alu_op = riscv_pkg::ALU_SLL;
                        // srai vs srli from funct7 bit 5
                        default               :
                            if (dec_i.funct7_b5)
                                ctrl_o.alu_op = riscv_pkg::ALU_SRA;
                            else
                                ctrl_o.alu_op = riscv_pkg::ALU_SRL;
                    endcase
                end
                else if (dec_i.opcode == riscv_pkg::LOAD)
                begin
                    // address = rs1 + imm, data from memory
                    ctrl_o.wb_sel = riscv_pkg::WB_MEM;
                    ctrl_o.rf_en  = (dec_i.funct3 == riscv_pkg::F3_LW);
                end
                else if (dec_i.funct3 == riscv_pkg::F3_JALR)
                begin
                    // jalr: target from alu, link pc+4
                    ctrl_o.pc_sel = riscv_pkg::PC_JALR;
                    ctrl_o.wb_sel = riscv_pkg::WB_PC4;
                end
                else
                    ctrl_o.rf_en = 1'b0;
            end

            riscv_pkg::FMT_S :
                // word store only
                ctrl_o.mem_wr = (dec_i.funct3 == riscv_pkg::F3_SW);

            riscv_pkg::FMT_B :
            begin
                ctrl_o.op2_sel = riscv_pkg::OP2_RS2;
                ctrl_o.pc_sel  = riscv_pkg::PC_BRANCH;
                case (dec_i.funct3)
                    riscv_pkg::F3_BEQ, riscv_pkg::F3_BNE   : ctrl_o.alu_op = riscv_pkg::ALU_SUB;
                    riscv_pkg::F3_BLT, riscv_pkg::F3_BGE   : ctrl_o.alu_op = riscv_pkg::ALU_SLT;
                    riscv_pkg::F3_BLTU, riscv_pkg::F3_BGEU : ctrl_o.alu_op = riscv_pkg::ALU_SLTU;
                    // funct3 010 and 011 undefined
                    default : ctrl_o.pc_sel = riscv_pkg::PC_PLUS4;
                endcase
            end

            riscv_pkg::FMT_U :
            begin
                ctrl_o.rf_en = 1'b1;
                // lui passes the immediate, auipc adds pc
                if (dec_i.opcode == riscv_pkg::LUI)
                    ctrl_o.alu_op  = riscv_pkg::ALU_PASS_B;
                else
                    ctrl_o.op1_sel = riscv_pkg::OP1_PC;
            end

            riscv_pkg::FMT_J :
            begin
                ctrl_o.pc_sel = riscv_pkg::PC_JUMP;
                ctrl_o.wb_sel = riscv_pkg::WB_PC4;
                ctrl_o.rf_en  = 1'b1;
            end

            default : ctrl_o = riscv_pkg::CTRL_NOP;
        endcase
    end

endmodule

// ==== riscv_regfile.sv ====
// Integer register file
`timescale 1ns/100ps

module riscv_regfile
    (
        input  logic                       clk_i,
        input  logic                       reset_i,
        input  logic [4:0]                 rs1_addr_i,
        input  logic [4:0]                 rs2_addr_i,
        input  logic [4:0]                 rd_addr_i,
        input  logic                       rd_we_i,
        input  logic [riscv_pkg::XLEN-1:0] rd_data_i,
        output logic [riscv_pkg::XLEN-1:0] rs1_data_o,
        output logic [riscv_pkg::XLEN-1:0] rs2_data_o
    );

    logic [riscv_pkg::XLEN-1:0] regs [32];

    // write on the edge, x0 never written
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (rd_we_i && (rd_addr_i != 5'd0))
            regs[rd_addr_i] <= rd_data_i;
    end

    // async reads, x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== riscv_alu.sv ====
// Integer ALU
`timescale 1ns/100ps

module riscv_alu
    (
        input  riscv_pkg::alu_op_e          op_i,
        input  logic [riscv_pkg::XLEN-1:0]  a_i,
        input  logic [riscv_pkg::XLEN-1:0]  b_i,
        output logic [riscv_pkg::XLEN-1:0]  result_o,
        output logic                        zero_o
    );

    // shift amount is the low 5 bits only
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb
    begin
        case (op_i)
            riscv_pkg::ALU_ADD    :
                result_o = a_i + b_i;
            riscv_pkg::ALU_SUB    :
                result_o = a_i - b_i;
            riscv_pkg::ALU_AND    :
                result_o = a_i & b_i;
            riscv_pkg::ALU_OR     :
                result_o = a_i | b_i;
            riscv_pkg::ALU_XOR    :
                result_o = a_i ^ b_i;
            riscv_pkg::ALU_SLL    :
                result_o = a_i << shamt;
            riscv_pkg::ALU_SRL    :
                result_o = a_i >> shamt;
            // sign bit fills from the left
            riscv_pkg::ALU_SRA    :
                result_o = $unsigned($signed(a_i) >>> shamt);
            // compares give 0 or 1 in bit 0
            riscv_pkg::ALU_SLT    :
                result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_signed};
            riscv_pkg::ALU_SLTU   :
                result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            // lui, immediate straight through
            riscv_pkg::ALU_PASS_B :
                result_o = b_i;
            default               :
                result_o = a_i + b_i;
        endcase
    end

    // beq/bne look at this after a subtract
    assign zero_o = (result_o == '0);

endmodule

// ==== riscv_pc_unit.sv ====
// Program counter and next-pc logic
`timescale 1ns/100ps

module riscv_pc_unit
    (
        input  logic                        clk_i,
        input  logic                        reset_i,
        input  riscv_pkg::pc_sel_e          pc_sel_i,
        input  logic [2:0]                  funct3_i,
        input  logic [riscv_pkg::XLEN-1:0]  alu_result_i,
        input  logic                        alu_zero_i,
        input  logic [riscv_pkg::XLEN-1:0]  imm_i,
        output logic [riscv_pkg::XLEN-1:0]  pc_o,
        output logic [riscv_pkg::XLEN-1:0]  pc_plus4_o
    );

    logic [riscv_pkg::XLEN-1:0] pc_target;
    logic [riscv_pkg::XLEN-1:0] jalr_target;
    logic [riscv_pkg::XLEN-1:0] pc_next;
    logic                       taken;

    assign pc_plus4_o  = pc_o + 32'd4;
    // branch and jal share one adder
    assign pc_target   = pc_o + imm_i;
    // jalr clears bit 0
    assign jalr_target = {alu_result_i[riscv_pkg::XLEN-1:1], 1'b0};

    // eq/ne from zero flag, the rest from slt(u) bit 0
    always_comb
    begin
        case (funct3_i)
            riscv_pkg::F3_BEQ  : taken = alu_zero_i;
            riscv_pkg::F3_BNE  : taken = ~alu_zero_i;
            riscv_pkg::F3_BLT  : taken = alu_result_i[0];
            riscv_pkg::F3_BGE  : taken = ~alu_result_i[0];
            riscv_pkg::F3_BLTU : taken = alu_result_i[0];
            riscv_pkg::F3_BGEU : taken = ~alu_result_i[0];
            default            : taken = 1'b0;
        endcase
    end

    always_comb
    begin
        case (pc_sel_i)
            riscv_pkg::PC_BRANCH : pc_next = taken ? pc_target : pc_plus4_o;
            riscv_pkg::PC_JUMP   : pc_next = pc_target;
            riscv_pkg::PC_JALR   : pc_next = jalr_target;
            default              : pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            pc_o <= riscv_pkg::RESET_PC;
        else
            pc_o <= pc_next;
    end

endmodule

// ==== riscv_core.sv ====
// Single-cycle RV32I core
`timescale 1ns/100ps

module riscv_core
    (
        input  logic                        clk_i,
        input  logic                        reset_i,
        output logic [riscv_pkg::XLEN-1:0]  imem_addr_o,
        input  logic [31:0]                 imem_data_i,
        output logic [riscv_pkg::XLEN-1:0]  dmem_addr_o,
        output logic [riscv_pkg::XLEN-1:0]  dmem_wdata_o,
        output logic                        dmem_we_o,
        input  logic [riscv_pkg::XLEN-1:0]  dmem_rdata_i
    );

    riscv_pkg::dec_t            dec;
    riscv_pkg::ctrl_t           ctrl;
    logic [riscv_pkg::XLEN-1:0] pc;
    logic [riscv_pkg::XLEN-1:0] pc_plus4;
    logic [riscv_pkg::XLEN-1:0] rs1_data;
    logic [riscv_pkg::XLEN-1:0] rs2_data;
    logic [riscv_pkg::XLEN-1:0] op_a;
    logic [riscv_pkg::XLEN-1:0] op_b;
    logic [riscv_pkg::XLEN-1:0] alu_result;
    logic                       alu_zero;
    logic [riscv_pkg::XLEN-1:0] wb_data;

    riscv_decode u_decode (.instr_i(imem_data_i), .dec_o(dec));

    riscv_control u_control (.dec_i(dec), .ctrl_o(ctrl));

    riscv_regfile u_regfile
    (
        .clk_i(clk_i), .reset_i(reset_i),
        .rs1_addr_i(dec.rs1), .rs2_addr_i(dec.rs2),
        .rd_addr_i(dec.rd), .rd_we_i(ctrl.rf_en), .rd_data_i(wb_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    // operand muxes, pc for auipc, imm for I/S/U
    assign op_a = (ctrl.op1_sel == riscv_pkg::OP1_PC)  ? pc : rs1_data;
    assign op_b = (ctrl.op2_sel == riscv_pkg::OP2_IMM) ? dec.imm : rs2_data;

    riscv_alu u_alu
    (
        .op_i(ctrl.alu_op), .a_i(op_a), .b_i(op_b),
        .result_o(alu_result), .zero_o(alu_zero)
    );

    riscv_pc_unit u_pc_unit
    (
        .clk_i(clk_i), .reset_i(reset_i),
        .pc_sel_i(ctrl.pc_sel), .funct3_i(dec.funct3),
        .alu_result_i(alu_result), .alu_zero_i(alu_zero), .imm_i(dec.imm),
        .pc_o(pc), .pc_plus4_o(pc_plus4)
    );

    // writeback select, pc+4 is the link value
    always_comb
    begin
        case (ctrl.wb_sel)
            riscv_pkg::WB_MEM : wb_data = dmem_rdata_i;
            riscv_pkg::WB_PC4 : wb_data = pc_plus4;
            default           : wb_data = alu_result;
        endcase
    end

    assign imem_addr_o  = pc;
    // load/store address from rs1 + imm
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    // no stray store while in reset
    assign dmem_we_o    = ctrl.mem_wr & ~reset_i;

endmodule

// ==== tb_clock.sv ====
// Testbench clock source
`timescale 1ns/100ps

module tb_clock
    (
        output logic clk_o
    );

    // 40 ns period, starts low
    initial
    begin
        clk_o = 1'b0;
        forever
            #20 clk_o = ~clk_o;
    end

endmodule

// ==== riscv_core_sva.sv ====
// Core interface assertions
`timescale 1ns/100ps

module riscv_core_sva
    (
        input logic                        clk_i,
        input logic                        reset_i,
        input logic [riscv_pkg::XLEN-1:0]  imem_addr_i,
        input logic                        dmem_we_i
    );

    // no store reaches memory while in reset
    we_low_in_reset : assert property (@(posedge clk_i) reset_i |-> !dmem_we_i)
        else $error("dmem_we_o high during reset");

    // fetch address on a word boundary
    pc_aligned : assert property (@(posedge clk_i) disable iff (reset_i)
        imem_addr_i[1:0] == 2'b00)
        else $error("imem_addr_o not word aligned");

    // first fetch after reset from the reset vector
    pc_after_reset : assert property (@(posedge clk_i)
        reset_i |=> imem_addr_i == riscv_pkg::RESET_PC)
        else $error("imem_addr_o not at reset pc after reset");

endmodule

bind riscv_core riscv_core_sva u_sva
(
    .clk_i(clk_i), .reset_i(reset_i),
    .imem_addr_i(imem_addr_o), .dmem_we_i(dmem_we_o)
);

// ==== riscv_core_tb.sv ====
// RV32I core testbench
`timescale 1ns/100ps

module riscv_core_tb;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    // word-addressed memory models of 1 KB each
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    // captured writes and the expected ones in order
    logic [31:0] wr_addr [$];
    logic [31:0] wr_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    // R-type ops as {funct7 bit 5, funct3}
    logic [3:0]  r_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    int          pc_w;
    int          prog_total;
    int          runs;
    int          errors;
    int          checks;
    longint      limit_ns;

    tb_clock u_clock (.clk_o(clk));

    riscv_core DUT
    (
        .clk_i(clk), .reset_i(reset),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_we_o(dmem_we), .dmem_rdata_i(dmem_rdata)
    );

    // both memories read combinationally
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // store lands on the edge and goes into the log
    always @(posedge clk)
    begin
        if (dmem_we)
        begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            wr_addr.push_back(dmem_addr);
            wr_data.push_back(dmem_wdata);
        end
    end

    // instruction encoders follow the ISA field layout
    function automatic logic [31:0] rtype(logic [3:0] op, int rd, int rs1, int rs2);
        return {1'b0, op[3], 5'b0, rs2[4:0], rs1[4:0], op[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(logic [6:0] opc, int f3, int rd, int rs1,
                                          logic [31:0] imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] stype(int rs2, int rs1, logic [31:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(int f3, int rs1, int rs2, logic [31:0] imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] utype(logic [6:0] opc, int rd, logic [31:0] imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] jtype(int rd, logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // preload pattern in which every address bit shows up
    function automatic logic [31:0] fill_word(int idx);
        return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a, idx[7:0] ^ 8'hc3};
    endfunction

    function automatic logic [31:0] sext12(logic [31:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // expected result per ISA definition of each op
    function automatic logic [31:0] alu_model(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            4'h0    : return a + b;
            4'h8    : return a - b;
            4'h1    : return a << b[4:0];
            4'h2    : return {31'b0, $signed(a) < $signed(b)};
            4'h3    : return {31'b0, a < b};
            4'h4    : return a ^ b;
            4'h5    : return a >> b[4:0];
            4'hd    : return $signed(a) >>> b[4:0];
            4'h6    : return a | b;
            default : return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0       : return a == b;
            1       : return a != b;
            4       : return $signed(a) < $signed(b);
            5       : return $signed(a) >= $signed(b);
            6       : return a < b;
            default : return a >= b;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic emit(logic [31:0] word);
        imem[pc_w[7:0]] = word;
        pc_w++;
        prog_total++;
    endtask

    // lui + addi with the upper part rounded for the signed low half
    task automatic load_const(int rd, logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        emit(utype(7'b0110111, rd, hi >> 12));
        emit(itype(7'b0010011, 0, rd, rd, v));
    endtask

    // sw rs to the next log slot with x0 as base
    task automatic expect_store(int rs, logic [31:0] value);
        logic [31:0] addr;
        addr = exp_addr.size() * 4;
        emit(stype(rs, 0, addr));
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    // reset goes up before the new program replaces the old one
    task automatic begin_program();
        @(negedge clk);
        reset = 1'b1;
        runs++;
        pc_w = 0;
        wr_addr.delete();
        wr_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic run_program(string name);
        logic [31:0] halt_pc;
        halt_pc = pc_w * 4;
        // terminal self-loop
        emit(jtype(0, 0));
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check_value({name, " imem_addr_o after reset"}, imem_addr, 32'h0);
        check_value({name, " writes during reset"}, wr_addr.size(), 0);
        while (imem_addr !== halt_pc)
            @(negedge clk);
        check_value({name, " write count"}, wr_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size() && i < wr_addr.size(); i++)
        begin
            check_value($sformatf("%s dmem_addr_o[%0d]", name, i), wr_addr[i], exp_addr[i]);
            check_value($sformatf("%s dmem_wdata_o[%0d]", name, i), wr_data[i], exp_data[i]);
        end
    endtask

    task automatic reset_test();
        begin_program();
        // a store sits at the reset pc for the whole reset
        expect_store(0, 32'h0);
        emit(itype(7'b0010011, 0, 1, 0, 32'h123));
        emit(itype(7'b0010011, 0, 2, 1, 32'h45));
        expect_store(2, 32'h168);
        run_program("reset");
    endtask

    task automatic rtype_test();
        logic [31:0] a;
        logic [31:0] b;
        begin_program();
        a = $urandom;
        b = $urandom;
        load_const(1, a);
        load_const(2, b);
        for (int i = 0; i < 10; i++)
        begin
            emit(rtype(r_ops[i], 3, 1, 2));
            expect_store(3, alu_model(r_ops[i], a, b));
        end
        run_program("rtype");
    endtask

    task automatic itype_test();
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] sh;
        begin_program();
        // negative operand so srai and srli differ
        a = $urandom | 32'h8000_0000;
        sh = ($urandom % 31) + 1;
        load_const(1, a);
        for (int i = 0; i < 8; i++)
        begin
            if (i != 1 && i != 5)
            begin
                imm = $urandom;
                emit(itype(7'b0010011, i, 3, 1, imm));
                expect_store(3, alu_model({1'b0, 3'(i)}, a, sext12(imm)));
            end
        end
        // sltiu compares against the sign-extended immediate
        imm = $urandom | 32'h800;
        emit(itype(7'b0010011, 3, 3, 1, imm));
        expect_store(3, alu_model(4'h3, a, sext12(imm)));
        emit(itype(7'b0010011, 1, 3, 1, sh));
        expect_store(3, alu_model(4'h1, a, sh));
        emit(itype(7'b0010011, 5, 3, 1, sh));
        expect_store(3, alu_model(4'h5, a, sh));
        emit(itype(7'b0010011, 5, 3, 1, sh | 32'h400));
        expect_store(3, alu_model(4'hd, a, sh));
        run_program("itype");
    endtask

    task automatic load_store_test();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] k;
        begin_program();
        v1 = fill_word(64);
        v2 = fill_word(65);
        k = $urandom & 32'h7ff;
        emit(itype(7'b0000011, 2, 1, 0, 32'd256));
        emit(itype(7'b0000011, 2, 2, 0, 32'd260));
        emit(rtype(4'h0, 3, 1, 2));
        expect_store(3, v1 + v2);
        emit(itype(7'b0010011, 0, 3, 3, k));
        expect_store(3, v1 + v2 + k);
        // read back what the last store wrote at address 4
        emit(itype(7'b0000011, 2, 4, 0, 32'd4));
        expect_store(4, v1 + v2 + k);
        // x0 ignores both a load and an addi
        emit(itype(7'b0000011, 2, 0, 0, 32'd256));
        emit(itype(7'b0010011, 0, 0, 1, 32'd5));
        expect_store(0, 32'h0);
        emit(rtype(4'h0, 5, 0, 1));
        expect_store(5, v1);
        run_program("load_store");
    endtask

    task automatic branch_test();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] a [3];
        logic [31:0] b [3];
        logic [31:0] mark;
        int          f3;
        begin_program();
        x = $urandom;
        y = $urandom;
        // equal, negative vs positive, positive vs negative
        a = '{x, x | 32'h8000_0000, y & 32'h7fff_ffff};
        b = '{x, y & 32'h7fff_ffff, x | 32'h8000_0000};
        for (int k = 0; k < 6; k++)
        begin
            f3 = (k < 2) ? k : k + 2;
            for (int p = 0; p < 3; p++)
            begin
                mark = exp_addr.size();
                load_const(1, a[p]);
                load_const(2, b[p]);
                // taken skips to the second marker
                emit(btype(f3, 1, 2, 32'd12));
                emit(itype(7'b0010011, 0, 3, 0, mark + 32'h200));
                emit(jtype(0, 32'd8));
                emit(itype(7'b0010011, 0, 3, 0, mark + 32'h100));
                expect_store(3, mark + (branch_taken(f3, a[p], b[p]) ? 32'h100 : 32'h200));
            end
        end
        run_program("branch");
    endtask

    task automatic jump_test();
        logic [31:0] imm;
        logic [31:0] at;
        begin_program();
        imm = $urandom;
        at = pc_w * 4;
        emit(utype(7'b0010111, 1, imm));
        expect_store(1, at + {imm[19:0], 12'b0});
        imm = $urandom;
        emit(utype(7'b0110111, 2, imm));
        expect_store(2, {imm[19:0], 12'b0});
        // jal over one addi links pc + 4
        at = pc_w * 4;
        emit(jtype(3, 32'd8));
        emit(itype(7'b0010011, 0, 4, 0, 32'd1));
        expect_store(3, at + 4);
        expect_store(4, 32'h0);
        // jalr lands two words on with bit 0 of the sum dropped
        at = (pc_w + 2) * 4;
        load_const(5, at + 8);
        emit(itype(7'b1100111, 0, 6, 5, 32'd1));
        emit(itype(7'b0010011, 0, 4, 0, 32'd7));
        expect_store(6, at + 4);
        expect_store(4, 32'h0);
        run_program("jump");
    endtask

    // budget grows with every program word and reset
    initial
    begin
        limit_ns = 0;
        while ($time <= limit_ns)
        begin
            @(posedge clk);
            limit_ns = longint'(prog_total + 10 * runs + 10) * 160;
        end
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        reset = 1'b1;
        pc_w = 0;
        prog_total = 0;
        runs = 0;
        errors = 0;
        checks = 0;
        void'($urandom(32'h47cd_0f94));
        for (int i = 0; i < 256; i++)
            dmem[i] <= fill_word(i);
        reset_test();
        rtype_test();
        itype_test();
        load_store_test();
        branch_test();
        jump_test();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== riscv_core.f ====
riscv_pkg.sv
riscv_decode.sv
riscv_control.sv
riscv_regfile.sv
riscv_alu.sv
riscv_pc_unit.sv
riscv_core.sv
tb_clock.sv
riscv_core_sva.sv
riscv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the riscv_core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module riscv_core_tb \
    -f riscv_core.f -o riscv_core_sim
./obj_dir/riscv_core_sim | tee sim.log
if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation clean"
